// ==== design/fetchPkg.sv ====
`default_nettype none

package fetchPkg;

    // primary opcodes.
    localparam logic [5:0] opRtype  = 6'h00;
    localparam logic [5:0] opRegimm = 6'h01;
    localparam logic [5:0] opJ      = 6'h02;
    localparam logic [5:0] opJal    = 6'h03;
    localparam logic [5:0] opBeq    = 6'h04;
    localparam logic [5:0] opBne    = 6'h05;
    localparam logic [5:0] opBlez   = 6'h06;
    localparam logic [5:0] opBgtz   = 6'h07;

    localparam logic [5:0] fnJr   = 6'h08; // funct field, R-type only.
    localparam logic [5:0] fnJalr = 6'h09;

    // REGIMM sub-codes sit in rt.
    localparam logic [4:0] rtBltz = 5'h00;
    localparam logic [4:0] rtBgez = 5'h01;

    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rFmt;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } iFmt;
        struct packed {
            logic [5:0]  op;
            logic [25:0] index26;
        } jFmt;
    } instrWord;

    // sll r0,r0,0.
    localparam instrWord nopWord = '0;

endpackage

`default_nettype wire

// ==== design/fetchPcReg.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchPcReg #(
    parameter logic [31:0] resetVector = 32'hbfc0_0000
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        flush,
    input  logic [31:0] flushPc,
    input  logic        stall,
    input  logic [31:0] nextPc,
    output logic [31:0] pcF,
    output logic        imemValid,
    output logic [31:0] imemAddr,
    output logic        addrError,
    output logic [31:0] badVaddr
);

    logic [31:0] reqAddr; // address presented to memory.
    logic        misaligned;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pcF     <= resetVector;
            reqAddr <= resetVector;
        end else if (flush) begin
            pcF     <= flushPc;
            reqAddr <= flushPc;
        end else if (!stall) begin
            pcF     <= nextPc;
            reqAddr <= nextPc;
        end else begin
            // reissue the held pc.
            reqAddr <= pcF;
        end
    end

    assign misaligned = (reqAddr[1:0] != 2'b00);

    // no fetch on a bad address, report it instead.
    assign imemValid = !misaligned;
    assign imemAddr  = misaligned ? 32'd0 : reqAddr;
    assign addrError = misaligned;
    assign badVaddr  = misaligned ? reqAddr : 32'd0;

    validAligned: assert property (
        @(posedge clk) disable iff (!resetn)
        imemValid |-> (pcF[1:0] == 2'b00)
    ) else $error("request issued on a misaligned address");

    bootVector: assert property (
        @(posedge clk)
        !resetn |=> (pcF == resetVector)
    ) else $error("pcF not at reset vector after reset");

endmodule

`default_nettype wire

// ==== design/decodeLatch.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeLatch (
    input  logic               clk,
    input  logic               resetn,
    input  logic               flush,
    input  logic               stall,
    input  logic [31:0]        pcF,
    input  logic [31:0]        imemData,
    output logic [31:0]        pcD,
    output fetchPkg::instrWord instrD
);

    // flush wins over stall.
    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            pcD    <= 32'd0;
            instrD <= fetchPkg::nopWord; // bubble.
        end else if (!stall) begin
            pcD    <= pcF;
            instrD <= imemData;
        end
    end

endmodule

`default_nettype wire

// ==== design/branchResolve.sv ====
`timescale 1ns/1ns
`default_nettype none

module branchResolve (
    input  fetchPkg::instrWord instrD,
    input  logic [31:0]        rsValue,
    input  logic [31:0]        rtValue,
    output logic               branchTaken
);

    logic signed [31:0] rsSigned;

    assign rsSigned = rsValue;

    always_comb begin
        case (instrD.iFmt.op)
            fetchPkg::opBeq: begin
                branchTaken = (rsValue == rtValue);
            end
            fetchPkg::opBne: begin
                branchTaken = (rsValue != rtValue);
            end
            fetchPkg::opBgtz: begin
                branchTaken = (rsSigned > 32'sd0);
            end
            fetchPkg::opBlez: begin
                branchTaken = (rsSigned <= 32'sd0);
            end
            fetchPkg::opRegimm: begin
                // rt picks the compare.
                case (instrD.iFmt.rt)
                    fetchPkg::rtBltz: branchTaken = (rsSigned < 32'sd0);
                    fetchPkg::rtBgez: branchTaken = (rsSigned >= 32'sd0);
                    default:          branchTaken = 1'b0;
                endcase
            end
            default: begin
                branchTaken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/nextPcSelect.sv ====
`timescale 1ns/1ns
`default_nettype none

module nextPcSelect (
    input  fetchPkg::instrWord instrD,
    input  logic [31:0]        pcD,
    input  logic [31:0]        pcF,
    input  logic [31:0]        rsValue,
    input  logic               branchTaken,
    output logic [31:0]        nextPc,
    output logic               delaySlot
);

    logic [31:0] pcPlusD;
    logic [31:0] pcPlusF;
    logic [31:0] signImm;
    logic [31:0] jumpTarget;
    logic [31:0] branchTarget;
    logic        isJump;
    logic        isRegJump;
    logic        isBranch;

    assign pcPlusD = pcD + 32'd4;
    assign pcPlusF = pcF + 32'd4; // sequential fetch.

    assign signImm      = {{16{instrD.iFmt.imm16[15]}}, instrD.iFmt.imm16};
    assign jumpTarget   = {pcPlusD[31:28], instrD.jFmt.index26, 2'b00};
    assign branchTarget = pcPlusD + {signImm[29:0], 2'b00};

    assign isJump = (instrD.jFmt.op == fetchPkg::opJ) ||
                    (instrD.jFmt.op == fetchPkg::opJal);

    assign isRegJump = (instrD.rFmt.op == fetchPkg::opRtype) &&
                       ((instrD.rFmt.funct == fetchPkg::fnJr) ||
                        (instrD.rFmt.funct == fetchPkg::fnJalr));

    // any REGIMM counts, taken or not.
    assign isBranch = (instrD.iFmt.op == fetchPkg::opBeq)  ||
                      (instrD.iFmt.op == fetchPkg::opBne)  ||
                      (instrD.iFmt.op == fetchPkg::opBlez) ||
                      (instrD.iFmt.op == fetchPkg::opBgtz) ||
                      (instrD.iFmt.op == fetchPkg::opRegimm);

    always_comb begin
        if (isJump) begin
            nextPc = jumpTarget;
        end else if (isRegJump) begin
            nextPc = rsValue;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlusF;
        end
    end

    // the word fetched next is the delay slot.
    assign delaySlot = isJump | isRegJump | isBranch;

    // resolver and selector must agree on what is a branch.
    always_comb begin
        if (!delaySlot) begin
            assert final (nextPc == pcPlusF)
                else $error("nextPc redirected with no branch or jump in decode");
        end
    end

endmodule

`default_nettype wire

// ==== design/fetchUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchUnit #(
    parameter logic [31:0] resetVector = 32'hbfc0_0000
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               stall,
    input  logic               flush,
    input  logic [31:0]        flushPc,
    input  logic [31:0]        imemData,
    input  logic [31:0]        rsValue,
    input  logic [31:0]        rtValue,
    output logic               imemValid,
    output logic [31:0]        imemAddr,
    output logic [31:0]        pcF,
    output logic [31:0]        pcD,
    output fetchPkg::instrWord instrD,
    output logic               delaySlot,
    output logic               addrError,
    output logic [31:0]        badVaddr
);

    logic [31:0] nextPc;
    logic        branchTaken;

    fetchPcReg #(
        .resetVector(resetVector)
    ) pcReg (
        .clk      (clk),
        .resetn   (resetn),
        .flush    (flush),
        .flushPc  (flushPc),
        .stall    (stall),
        .nextPc   (nextPc),
        .pcF      (pcF),
        .imemValid(imemValid),
        .imemAddr (imemAddr),
        .addrError(addrError),
        .badVaddr (badVaddr)
    );

    decodeLatch dLatch (
        .clk     (clk),
        .resetn  (resetn),
        .flush   (flush),
        .stall   (stall),
        .pcF     (pcF),
        .imemData(imemData),
        .pcD     (pcD),
        .instrD  (instrD)
    );

    branchResolve bResolve (
        .instrD     (instrD),
        .rsValue    (rsValue),
        .rtValue    (rtValue),
        .branchTaken(branchTaken)
    );

    nextPcSelect npcSelect (
        .instrD     (instrD),
        .pcD        (pcD),
        .pcF        (pcF),
        .rsValue    (rsValue),
        .branchTaken(branchTaken),
        .nextPc     (nextPc),
        .delaySlot  (delaySlot)
    );

endmodule

`default_nettype wire

// ==== test/fetchUnitTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchUnitTb;

    localparam logic [31:0] defaultVector = 32'hbfc0_0000;
    localparam logic [31:0] altVector     = 32'h0000_2000;
    localparam int          stimCycles    = 3000;
    localparam int          timeoutCycles = 4000; // reset plus stimulus, with headroom.

    logic               clk;
    logic               resetn;
    logic               stall;
    logic               flush;
    logic [31:0]        flushPc;
    logic [31:0]        imemData;
    logic [31:0]        rsValue;
    logic [31:0]        rtValue;
    logic               imemValid;
    logic [31:0]        imemAddr;
    logic [31:0]        pcF;
    logic [31:0]        pcD;
    fetchPkg::instrWord instrD;
    logic               delaySlot;
    logic               addrError;
    logic [31:0]        badVaddr;
    logic [31:0]        altPcF;

    logic [31:0] progMem [0:4095];
    logic [31:0] rsTable [0:4095]; // operands, one pair per word.
    logic [31:0] rtTable [0:4095];

    fetchPkg::instrWord expInstr;
    logic [31:0]        expPcF;
    logic [31:0]        predPcF;
    logic [31:0]        expPcD;
    logic [31:0]        altExp;
    logic               armed;
    int                 errorCount;
    int                 cycleCount;

    fetchUnit UUT (
        .clk(clk), .resetn(resetn), .stall(stall), .flush(flush), .flushPc(flushPc),
        .imemData(imemData), .rsValue(rsValue), .rtValue(rtValue),
        .imemValid(imemValid), .imemAddr(imemAddr), .pcF(pcF), .pcD(pcD),
        .instrD(instrD), .delaySlot(delaySlot), .addrError(addrError), .badVaddr(badVaddr)
    );

    // second copy only shows that the boot address is a parameter.
    fetchUnit #(.resetVector(altVector)) altUut (
        .clk(clk), .resetn(resetn), .stall(1'b0), .flush(1'b0), .flushPc(32'd0),
        .imemData(32'd0), .rsValue(32'd0), .rtValue(32'd0),
        .imemValid(), .imemAddr(), .pcF(altPcF), .pcD(), .instrD(),
        .delaySlot(), .addrError(), .badVaddr()
    );

    assign imemData = imemValid ? progMem[imemAddr[13:2]] : 32'd0;
    assign rsValue  = rsTable[pcD[13:2]];
    assign rtValue  = rtTable[pcD[13:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abortRun();
        errorCount = errorCount + 1;
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] expVal,
                             input logic [31:0] gotVal);
        if (gotVal !== expVal) begin
            $display("ERR %s expected %h got %h", name, expVal, gotVal);
            abortRun();
        end
    endtask

    task automatic checkInstr(input string name, input fetchPkg::instrWord expVal,
                              input fetchPkg::instrWord gotVal);
        if (gotVal !== expVal) begin
            $display("ERR %s expected %h got %h", name, expVal, gotVal);
            abortRun();
        end
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic gotVal);
        if (gotVal !== expVal) begin
            $display("ERR %s expected %h got %h", name, expVal, gotVal);
            abortRun();
        end
    endtask

    function automatic logic isTransfer(input fetchPkg::instrWord instr);
        logic regJump;
        regJump = (instr.rFmt.op == fetchPkg::opRtype) &&
                  (instr.rFmt.funct == fetchPkg::fnJr || instr.rFmt.funct == fetchPkg::fnJalr);
        return regJump || instr.jFmt.op inside {fetchPkg::opJ, fetchPkg::opJal,
            fetchPkg::opBeq, fetchPkg::opBne, fetchPkg::opBlez, fetchPkg::opBgtz,
            fetchPkg::opRegimm};
    endfunction

    function automatic logic [31:0] nextPcRef(input fetchPkg::instrWord instr,
            input logic [31:0] pcDec, input logic [31:0] pcFet, input logic [31:0] rs,
            input logic [31:0] rt, input logic stallIn, input logic flushIn,
            input logic [31:0] flushTarget);
        logic [31:0] slotPc;
        logic [31:0] offset;
        logic        taken;
        slotPc = pcDec + 32'd4;
        offset = {{14{instr.iFmt.imm16[15]}}, instr.iFmt.imm16, 2'b00};
        taken  = 1'b0;
        if (flushIn) return flushTarget;
        if (stallIn) return pcFet;
        case (instr.iFmt.op)
            fetchPkg::opJ, fetchPkg::opJal: return {slotPc[31:28], instr.jFmt.index26, 2'b00};
            fetchPkg::opRtype: begin
                if (instr.rFmt.funct == fetchPkg::fnJr || instr.rFmt.funct == fetchPkg::fnJalr)
                    return rs;
            end
            fetchPkg::opBeq:  taken = (rs == rt);
            fetchPkg::opBne:  taken = (rs != rt);
            fetchPkg::opBgtz: taken = !rs[31] && (rs != 32'd0);
            fetchPkg::opBlez: taken = rs[31] || (rs == 32'd0);
            fetchPkg::opRegimm: begin
                if (instr.iFmt.rt == fetchPkg::rtBltz) taken = rs[31];
                else if (instr.iFmt.rt == fetchPkg::rtBgez) taken = !rs[31];
            end
            default: taken = 1'b0;
        endcase
        return taken ? slotPc + offset : pcFet + 32'd4;
    endfunction

    function automatic fetchPkg::instrWord fetchedWord(input logic [31:0] addr);
        if (addr[1:0] != 2'b00) return fetchPkg::nopWord; // no request, memory gives zero.
        return progMem[addr[13:2]];
    endfunction

    task automatic loadProgram();
        fetchPkg::instrWord w;
        logic [31:0]        target;
        logic [15:0]        offs;
        int                 kind;
        for (int k = 0; k < 4096; k++) begin
            w    = '0;
            kind = (k < 16) ? 0 : int'($urandom % 20); // straight-line boot code.
            w.rFmt.rs = 5'($urandom);
            w.rFmt.rt = 5'($urandom);
            offs = 16'($urandom % 17) - 16'd8;
            if (kind < 10) begin
                w.rFmt.rd    = 5'($urandom);
                w.rFmt.funct = 6'h20 + 6'($urandom % 8);
            end else if (kind < 12) begin
                w.jFmt.op      = (kind == 10) ? fetchPkg::opJ : fetchPkg::opJal;
                w.jFmt.index26 = {defaultVector[27:14], 12'($urandom)};
            end else if (kind < 18) begin
                w.iFmt.imm16 = offs;
                case (kind)
                    12: w.iFmt.op = fetchPkg::opBeq;
                    13: w.iFmt.op = fetchPkg::opBne;
                    14: w.iFmt.op = fetchPkg::opBlez;
                    15: w.iFmt.op = fetchPkg::opBgtz;
                    default: begin
                        w.iFmt.op = fetchPkg::opRegimm;
                        w.iFmt.rt = (kind == 16) ? fetchPkg::rtBltz : fetchPkg::rtBgez;
                    end
                endcase
            end else begin
                w.rFmt.rt    = 5'd0;
                w.rFmt.rd    = (kind == 18) ? 5'd0 : 5'd31;
                w.rFmt.funct = (kind == 18) ? fetchPkg::fnJr : fetchPkg::fnJalr;
            end
            progMem[k] = w;
            rsTable[k] = $urandom;
            rtTable[k] = ($urandom % 3 == 0) ? rsTable[k] : $urandom;
            if ($urandom % 8 == 0) rsTable[k] = 32'd0; // edge of the zero compares.
            if (kind >= 18) begin
                target = {defaultVector[31:14], 12'($urandom), 2'b00};
                if ($urandom % 32 == 0) target[1:0] = 2'd1 + 2'($urandom % 3);
                rsTable[k] = target;
            end
        end
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", timeoutCycles);
            abortRun();
        end
    end

    // compare the state from the last edge, then predict the next one.
    always @(posedge clk) begin
        if (armed) begin
            checkWord("pcF", expPcF, pcF);
            checkWord("pcD", expPcD, pcD);
            checkInstr("instrD", expInstr, instrD);
            checkBit("imemValid", expPcF[1:0] == 2'b00, imemValid);
            checkWord("imemAddr", (expPcF[1:0] == 2'b00) ? expPcF : 32'd0, imemAddr);
            checkBit("addrError", expPcF[1:0] != 2'b00, addrError);
            checkWord("badVaddr", (expPcF[1:0] != 2'b00) ? expPcF : 32'd0, badVaddr);
            checkBit("delaySlot", isTransfer(expInstr), delaySlot);
            checkWord("altPcF", altExp, altPcF);
        end
        if (!resetn) begin
            expPcF   = defaultVector;
            expPcD   = 32'd0;
            expInstr = fetchPkg::nopWord;
            altExp   = altVector;
            armed    = 1'b1;
        end else begin
            altExp  = altExp + 32'd4;
            predPcF = nextPcRef(expInstr, expPcD, expPcF, rsTable[expPcD[13:2]],
                                rtTable[expPcD[13:2]], stall, flush, flushPc);
            if (flush) begin
                expPcD   = 32'd0;
                expInstr = fetchPkg::nopWord;
            end else if (!stall) begin
                expPcD   = expPcF;
                expInstr = fetchedWord(expPcF);
            end
            expPcF = predPcF;
        end
    end

    initial begin
        armed      = 1'b0;
        errorCount = 0;
        cycleCount = 0;
        void'($urandom(56));
        resetn     = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        flushPc    = 32'd0;
        loadProgram();
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        for (int i = 0; i < stimCycles; i++) begin
            @(posedge clk);
            if (i >= 16) begin
                stall   <= ($urandom % 6 == 0);
                flushPc <= {defaultVector[31:14], 12'($urandom), 2'b00};
                if (flush)
                    flush <= 1'b0;
                else if (addrError)
                    flush <= 1'b1; // exception redirect after a bad fetch.
                else
                    flush <= ($urandom % 64 == 0);
            end
        end
        @(posedge clk);
        if (errorCount == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abortRun();
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
design/fetchPkg.sv
design/fetchPcReg.sv
design/decodeLatch.sv
design/branchResolve.sv
design/nextPcSelect.sv
design/fetchUnit.sv
test/fetchUnitTb.sv
